// File: src/gpr_pkg.sv
/*
 * GPR register file shared definitions.
 * Widths, bank geometry and the write-request struct.
 */

`default_nettype none

package gpr_pkg;

   // ----------------------------------------
   // Entry geometry
   // ----------------------------------------
   localparam int GPR_WIDTH       = 64;
   localparam int GPR_CHECK_BITS  = 14;
   localparam int ENTRY_WIDTH     = GPR_WIDTH + GPR_CHECK_BITS;

   // Full address, upper bits pick the bank
   localparam int ADDR_WIDTH      = 8;
   localparam int BANK_ADDR_WIDTH = 6;
   localparam int BANK_DEPTH      = 1 << BANK_ADDR_WIDTH;

   localparam int NUM_WRITE_PORTS = 4;

   typedef logic [ENTRY_WIDTH-1:0] gpr_entry_t;
   typedef logic [ADDR_WIDTH-1:0]  gpr_addr_t;

   // One write port, 87 bits
   typedef struct packed {
      logic       en;
      gpr_addr_t  addr;
      gpr_entry_t data;
   } gpr_wr_t;

endpackage

`default_nettype wire

// File: src/gpr_write_stage.sv
/*
 * GPR write stage. Registers the four write ports and drops any write
 * that a higher-numbered port overrides in the same cycle.
 */

`default_nettype none

module gpr_write_stage
#(
   parameter int ENTRIES = 144
)
(
   input  logic                                          nclk,
   input  logic                                          rst_n,
   input  gpr_pkg::gpr_wr_t [gpr_pkg::NUM_WRITE_PORTS-1:0] w_req,
   output gpr_pkg::gpr_wr_t [gpr_pkg::NUM_WRITE_PORTS-1:0] wr_q
);

   import gpr_pkg::*;

   logic [NUM_WRITE_PORTS-1:0]       keep;
   logic [NUM_WRITE_PORTS-1:0]       en_q;
   gpr_addr_t [NUM_WRITE_PORTS-1:0]  addr_q;
   gpr_entry_t [NUM_WRITE_PORTS-1:0] data_q;

   // ----------------------------------------
   // Same-address override
   // ----------------------------------------
   // A higher-numbered port wins a shared address
   always_comb
   begin
      for (int p = 0; p < NUM_WRITE_PORTS; p++)
      begin
         keep[p] = w_req[p].en && (32'(w_req[p].addr) < ENTRIES);
         for (int q = p + 1; q < NUM_WRITE_PORTS; q++)
         begin
            if (w_req[q].en && (w_req[q].addr == w_req[p].addr))
            begin
               keep[p] = 1'b0;
            end
         end
      end
   end

   always_ff @(posedge nclk)
   begin
      if (!rst_n)
      begin
         en_q <= '0;
      end
      else
      begin
         en_q <= keep;
      end
   end

   // Payload registers
   always_ff @(posedge nclk)
   begin
      for (int p = 0; p < NUM_WRITE_PORTS; p++)
      begin
         addr_q[p] <= w_req[p].addr;
         data_q[p] <= w_req[p].data;
      end
   end

   always_comb
   begin
      for (int p = 0; p < NUM_WRITE_PORTS; p++)
      begin
         wr_q[p] = '{en: en_q[p], addr: addr_q[p], data: data_q[p]};
      end
   end

endmodule

`default_nettype wire

// File: src/gpr_bank.sv
/*
 * GPR bank. One 64-row slice of the register array with its own
 * bank-index write decode and two asynchronous read ports.
 */

`default_nettype none

module gpr_bank
#(
   parameter int BANK_INDEX = 0
)
(
   input  logic                                          nclk,
   input  gpr_pkg::gpr_wr_t [gpr_pkg::NUM_WRITE_PORTS-1:0] wr_q,
   input  logic [gpr_pkg::BANK_ADDR_WIDTH-1:0]            rd_row_1,
   input  logic [gpr_pkg::BANK_ADDR_WIDTH-1:0]            rd_row_2,
   output gpr_pkg::gpr_entry_t                           rd_entry_1,
   output gpr_pkg::gpr_entry_t                           rd_entry_2
);

   import gpr_pkg::*;

   localparam int SEL_WIDTH = ADDR_WIDTH - BANK_ADDR_WIDTH;
   localparam logic [SEL_WIDTH-1:0] BANK_SEL = SEL_WIDTH'(BANK_INDEX);

   gpr_entry_t mem [BANK_DEPTH];

   logic [NUM_WRITE_PORTS-1:0] wr_hit;

   // ----------------------------------------
   // Write decode
   // ----------------------------------------
   always_comb
   begin
      for (int p = 0; p < NUM_WRITE_PORTS; p++)
      begin
         wr_hit[p] = wr_q[p].en &&
                     (wr_q[p].addr[ADDR_WIDTH-1:BANK_ADDR_WIDTH] == BANK_SEL);
      end
   end

   // All surviving writes land on the same edge.
   // Rows never collide here, the write stage already removed overrides
   always_ff @(posedge nclk)
   begin
      for (int p = 0; p < NUM_WRITE_PORTS; p++)
      begin
         if (wr_hit[p])
         begin
            mem[wr_q[p].addr[BANK_ADDR_WIDTH-1:0]] <= wr_q[p].data;
         end
      end
   end

   // ----------------------------------------
   // Read ports
   // ----------------------------------------
   assign rd_entry_1 = mem[rd_row_1];
   assign rd_entry_2 = mem[rd_row_2];

endmodule

`default_nettype wire

// File: src/gpr_read_port.sv
/*
 * GPR read port. Registers the read address, picks the addressed bank
 * and registers the selected entry, zero when no bank matches.
 */

`default_nettype none

module gpr_read_port
#(
   parameter int  ENTRIES   = 144,
   localparam int NUM_BANKS = (ENTRIES + gpr_pkg::BANK_DEPTH - 1) / gpr_pkg::BANK_DEPTH
)
(
   input  logic                                   nclk,
   input  logic                                   rst_n,
   input  gpr_pkg::gpr_addr_t                     addr,
   output logic [gpr_pkg::BANK_ADDR_WIDTH-1:0]    rd_row,
   input  gpr_pkg::gpr_entry_t [NUM_BANKS-1:0]    bank_entries,
   output gpr_pkg::gpr_entry_t                    data
);

   import gpr_pkg::*;

   localparam int SEL_WIDTH = ADDR_WIDTH - BANK_ADDR_WIDTH;

   gpr_addr_t            addr_q;
   logic [SEL_WIDTH-1:0] bank_sel;
   logic [NUM_BANKS-1:0] bank_hit;
   gpr_entry_t           sel_entry;

   always_ff @(posedge nclk)
   begin
      if (!rst_n)
      begin
         addr_q <= '0;
      end
      else
      begin
         addr_q <= addr;
      end
   end

   assign rd_row   = addr_q[BANK_ADDR_WIDTH-1:0];
   assign bank_sel = addr_q[ADDR_WIDTH-1:BANK_ADDR_WIDTH];

   // ----------------------------------------
   // Bank select, AND-OR mux
   // ----------------------------------------
   always_comb
   begin
      sel_entry = '0;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
         bank_hit[b] = (bank_sel == SEL_WIDTH'(b));
         sel_entry   = sel_entry | (bank_entries[b] & {ENTRY_WIDTH{bank_hit[b]}});
      end
   end

   always_ff @(posedge nclk)
   begin
      if (!rst_n)
      begin
         data <= '0;
      end
      else
      begin
         data <= sel_entry;
      end
   end

endmodule

`default_nettype wire

// File: src/gpr_regfile_2r4w.sv
/*
 * GPR register file, 144 x 78 bits, four write ports and two read ports.
 * Writes are registered then land together on the next edge; each read
 * port has one cycle of latency from its registered address.
 */

`default_nettype none

module gpr_regfile_2r4w
#(
   parameter int ENTRIES = 144
)
(
   input  logic                                          nclk,
   input  logic                                          rst_n,
   input  gpr_pkg::gpr_wr_t [gpr_pkg::NUM_WRITE_PORTS-1:0] w_req,
   input  gpr_pkg::gpr_addr_t                            r_addr_1,
   input  gpr_pkg::gpr_addr_t                            r_addr_2,
   output gpr_pkg::gpr_entry_t                           r_data_1,
   output gpr_pkg::gpr_entry_t                           r_data_2
);

   import gpr_pkg::*;

   // Whole banks only, 3 for 144 entries
   localparam int NUM_BANKS = (ENTRIES + BANK_DEPTH - 1) / BANK_DEPTH;

   gpr_wr_t [NUM_WRITE_PORTS-1:0] wr_q;
   logic [BANK_ADDR_WIDTH-1:0]    rd_row_1;
   logic [BANK_ADDR_WIDTH-1:0]    rd_row_2;
   gpr_entry_t [NUM_BANKS-1:0]    bank_entries_1;
   gpr_entry_t [NUM_BANKS-1:0]    bank_entries_2;

   // ----------------------------------------
   // Write side
   // ----------------------------------------
   gpr_write_stage #(
      .ENTRIES (ENTRIES)
   ) u_write_stage (
      .nclk  (nclk),
      .rst_n (rst_n),
      .w_req (w_req),
      .wr_q  (wr_q)
   );

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      gpr_bank #(
         .BANK_INDEX (b)
      ) u_bank (
         .nclk       (nclk),
         .wr_q       (wr_q),
         .rd_row_1   (rd_row_1),
         .rd_row_2   (rd_row_2),
         .rd_entry_1 (bank_entries_1[b]),
         .rd_entry_2 (bank_entries_2[b])
      );
   end

   // ----------------------------------------
   // Read side
   // ----------------------------------------
   gpr_read_port #(
      .ENTRIES (ENTRIES)
   ) u_read_port_1 (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .addr         (r_addr_1),
      .rd_row       (rd_row_1),
      .bank_entries (bank_entries_1),
      .data         (r_data_1)
   );

   gpr_read_port #(
      .ENTRIES (ENTRIES)
   ) u_read_port_2 (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .addr         (r_addr_2),
      .rd_row       (rd_row_2),
      .bank_entries (bank_entries_2),
      .data         (r_data_2)
   );

endmodule

`default_nettype wire

// File: sim/tb_gpr_util.svh
/*
 * GPR register file testbench helpers.
 * LFSR stimulus source, shadow array and mismatch reporting.
 */

`ifndef TB_GPR_UTIL_SVH
`define TB_GPR_UTIL_SVH

// ----------------------------------------
// Fibonacci LFSR, taps 16 14 13 11
// ----------------------------------------
logic [15:0] lfsr_state = 16'd59;

// One LFSR step per returned bit
function automatic gpr_entry_t take_bits(input int n);
   gpr_entry_t bits;
   logic       fb;
   bits = '0;
   for (int i = 0; i < n; i++)
   begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      bits       = {bits[ENTRY_WIDTH-2:0], fb};
   end
   return bits;
endfunction

// Shadow copy of the register array
gpr_entry_t model_mem [TB_ENTRIES];

int errors = 0;
int checks = 0;

task automatic report_mismatch(input string name, input gpr_entry_t got, input gpr_entry_t exp);
   $display("[FAIL] %s at %0t ns: got 0x%h, expected 0x%h", name, $time, got, exp);
   errors++;
endtask

`endif

// File: sim/tb_gpr_regfile_2r4w.sv
/*
 * Testbench for the 2-read 4-write GPR register file.
 * Drives directed and LFSR stimulus and checks both read ports
 * against a shadow model of the array.
 */

`default_nettype none

module tb_gpr_regfile_2r4w;

   timeunit 1ns;
   timeprecision 1ps;

   import gpr_pkg::*;

   localparam int TB_ENTRIES     = 144;
   localparam int TB_BANKS       = (TB_ENTRIES + BANK_DEPTH - 1) / BANK_DEPTH;
   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 8;
   localparam int PRELOAD_CYCLES = TB_ENTRIES / NUM_WRITE_PORTS;
   localparam int DIRECTED_CYCLES = 40;
   localparam int RANDOM_CYCLES  = 400;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + PRELOAD_CYCLES + DIRECTED_CYCLES
                                   + RANDOM_CYCLES + 100;

   logic                          nclk;
   logic                          rst_n;
   gpr_wr_t [NUM_WRITE_PORTS-1:0] w_req;
   gpr_addr_t                     r_addr_1;
   gpr_addr_t                     r_addr_2;
   gpr_entry_t                    r_data_1;
   gpr_entry_t                    r_data_2;

   // Values under check and values for the read still in flight
   logic       chk_valid_1  = 1'b0;
   logic       chk_valid_2  = 1'b0;
   logic       next_valid_1 = 1'b0;
   logic       next_valid_2 = 1'b0;
   gpr_entry_t exp_data_1   = '0;
   gpr_entry_t exp_data_2   = '0;
   gpr_entry_t next_data_1  = '0;
   gpr_entry_t next_data_2  = '0;

   gpr_wr_t [NUM_WRITE_PORTS-1:0] prev_req  = '0;
   gpr_addr_t                     prev_ra_1 = 8'hFF;
   gpr_addr_t                     prev_ra_2 = 8'hFF;

   `include "tb_gpr_util.svh"

   gpr_regfile_2r4w #(
      .ENTRIES (TB_ENTRIES)
   ) DUT (
      .nclk     (nclk),
      .rst_n    (rst_n),
      .w_req    (w_req),
      .r_addr_1 (r_addr_1),
      .r_addr_2 (r_addr_2),
      .r_data_1 (r_data_1),
      .r_data_2 (r_data_2)
   );

   initial
   begin
      nclk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2);
         nclk = ~nclk;
      end
   end

   // ----------------------------------------
   // Shadow model
   // ----------------------------------------
   // Ports 1 to 4 in order so the later port overwrites
   task automatic apply_writes(input gpr_wr_t [NUM_WRITE_PORTS-1:0] req);
      for (int p = 0; p < NUM_WRITE_PORTS; p++)
      begin
         if (req[p].en && int'(req[p].addr) < TB_ENTRIES)
         begin
            model_mem[req[p].addr] = req[p].data;
         end
      end
   endtask

   function automatic logic expect_read(input gpr_addr_t addr, output gpr_entry_t value);
      value = '0;
      if (int'(addr) < TB_ENTRIES)
      begin
         value = model_mem[addr];
         return 1'b1;
      end
      // Addresses past the last bank read as zero
      return int'(addr) >= TB_BANKS * BANK_DEPTH;
   endfunction

   // Model update for one clock before the next inputs go out
   task automatic step(input gpr_wr_t [NUM_WRITE_PORTS-1:0] req,
                       input gpr_addr_t ra1, input gpr_addr_t ra2);
      @(posedge nclk);
      #2;
      chk_valid_1  = next_valid_1;
      chk_valid_2  = next_valid_2;
      exp_data_1   = next_data_1;
      exp_data_2   = next_data_2;
      // Read sampled at this edge sees writes from earlier edges only
      next_valid_1 = expect_read(prev_ra_1, next_data_1);
      next_valid_2 = expect_read(prev_ra_2, next_data_2);
      apply_writes(prev_req);
      w_req     = req;
      r_addr_1  = ra1;
      r_addr_2  = ra2;
      prev_req  = req;
      prev_ra_1 = ra1;
      prev_ra_2 = ra2;
   endtask

   function automatic gpr_addr_t rand_addr();
      return gpr_addr_t'(int'(take_bits(ADDR_WIDTH)) % TB_ENTRIES);
   endfunction

   // ----------------------------------------
   // Checking
   // ----------------------------------------
   assert property (@(negedge nclk) chk_valid_1 |-> r_data_1 === exp_data_1)
      else report_mismatch("r_data_1", r_data_1, exp_data_1);

   assert property (@(negedge nclk) chk_valid_2 |-> r_data_2 === exp_data_2)
      else report_mismatch("r_data_2", r_data_2, exp_data_2);

   always @(negedge nclk)
   begin
      checks <= checks + int'(chk_valid_1) + int'(chk_valid_2);
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge nclk);
      $display("Watchdog expired after %0d cycles, stimulus never finished", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial
   begin
      gpr_wr_t [NUM_WRITE_PORTS-1:0] req;
      gpr_addr_t                     corners [6];
      corners  = '{8'd0, 8'd63, 8'd64, 8'd127, 8'd128, 8'd143};
      rst_n    = 1'b0;
      w_req    = '0;
      r_addr_1 = 8'hFF;
      r_addr_2 = 8'hFF;
      // Outputs must read zero from the first reset edge on
      @(posedge nclk);
      #2;
      chk_valid_1 = 1'b1;
      chk_valid_2 = 1'b1;
      repeat (RESET_CYCLES - 1) @(posedge nclk);
      #2;
      rst_n = 1'b1;

      // Fill every entry with four distinct addresses per cycle
      for (int a = 0; a < TB_ENTRIES; a += NUM_WRITE_PORTS)
      begin
         for (int p = 0; p < NUM_WRITE_PORTS; p++)
         begin
            req[p] = '{en: 1'b1, addr: gpr_addr_t'(a + p), data: take_bits(ENTRY_WIDTH)};
         end
         step(req, 8'hFF, 8'hC0);
      end

      // First and last rows of each bank through the ports in turn
      for (int i = 0; i < 6; i++)
      begin
         req = '0;
         req[i % NUM_WRITE_PORTS] = '{en: 1'b1, addr: corners[i], data: take_bits(ENTRY_WIDTH)};
         step(req, 8'hFF, 8'hFF);
      end
      for (int i = 0; i < 6; i++)
      begin
         step('0, corners[i], corners[5 - i]);
      end

      // Four ports on four distinct addresses
      req[0] = '{en: 1'b1, addr: 8'd5, data: take_bits(ENTRY_WIDTH)};
      req[1] = '{en: 1'b1, addr: 8'd70, data: take_bits(ENTRY_WIDTH)};
      req[2] = '{en: 1'b1, addr: 8'd130, data: take_bits(ENTRY_WIDTH)};
      req[3] = '{en: 1'b1, addr: 8'd140, data: take_bits(ENTRY_WIDTH)};
      step(req, 8'hFF, 8'hFF);
      step('0, 8'd5, 8'd70);
      step('0, 8'd130, 8'd140);

      // Two, three and four ports on one address
      for (int n = 2; n <= NUM_WRITE_PORTS; n++)
      begin
         req = '0;
         for (int p = 0; p < n; p++)
         begin
            req[p] = '{en: 1'b1, addr: gpr_addr_t'(30 * n + 1), data: take_bits(ENTRY_WIDTH)};
         end
         step(req, 8'hFF, 8'hFF);
         step('0, gpr_addr_t'(30 * n + 1), gpr_addr_t'(30 * n + 1));
      end

      // Disabled port 4 on the same address must not win
      req[0] = '{en: 1'b1, addr: 8'd100, data: take_bits(ENTRY_WIDTH)};
      req[1] = '{en: 1'b1, addr: 8'd101, data: take_bits(ENTRY_WIDTH)};
      req[2] = '{en: 1'b1, addr: 8'd100, data: take_bits(ENTRY_WIDTH)};
      req[3] = '{en: 1'b0, addr: 8'd100, data: take_bits(ENTRY_WIDTH)};
      step(req, 8'hFF, 8'hFF);
      step('0, 8'd100, 8'd101);

      // Read on the write edge gets old data and one cycle later new data
      req    = '0;
      req[2] = '{en: 1'b1, addr: 8'd10, data: take_bits(ENTRY_WIDTH)};
      step(req, 8'd10, 8'd10);
      step('0, 8'd10, 8'd10);

      for (int c = 0; c < RANDOM_CYCLES; c++)
      begin
         for (int p = 0; p < NUM_WRITE_PORTS; p++)
         begin
            req[p].en   = 1'(take_bits(1));
            req[p].addr = rand_addr();
            req[p].data = take_bits(ENTRY_WIDTH);
         end
         step(req, rand_addr(), rand_addr());
      end

      // Let the last reads come out
      repeat (2) step('0, 8'hFF, 8'hFF);
      @(negedge nclk);
      #1;
      $display("Read checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
src/gpr_pkg.sv
src/gpr_write_stage.sv
src/gpr_bank.sv
src/gpr_read_port.sv
src/gpr_regfile_2r4w.sv
sim/tb_gpr_regfile_2r4w.sv

// File: run.sh
#!/bin/sh
# Builds and runs the GPR register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
   --top-module tb_gpr_regfile_2r4w -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vtb_gpr_regfile_2r4w)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qxF '*** TEST PASSED ***'; then
   exit 0
fi
exit 1
